//--- Makefile
# Verilator build and run of the PUF session handler testbench

VERILATOR ?= verilator
TOP       ?= sircPufTb
FLIST     ?= sircPuf.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
DATA      ?= sim/sircPufTestdata.txt
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Testbench passed

SRCS    := $(shell grep -v '^+' $(FLIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN) $(DATA)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- rtl/challengeLoader.sv
/* Configuration loader: reads 16 bytes from the input memory, one read
   outstanding, and packs them into the 128-bit delay-line configuration */
`default_nettype none

module challengeLoader (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         start,     // Pulse from sequencer
	output sircPufPkg::inMemReq_t        inMem,
	input  sircPufPkg::inMemResp_t       inResp,
	output logic [sircPufPkg::CFG_W-1:0] pdlConfig, // Byte i at bit 8*i
	output logic                         loadDone   // One-cycle pulse
);
	import sircPufPkg::*;

	localparam int               IDX_W    = $clog2(CFG_BYTES);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(CFG_BYTES - 1);

	logic                      readReq;  // Request held until ack
	logic                      pending;  // Read accepted, data not back yet
	logic [IDX_W-1:0]          byteIdx;  // Current address and byte slot
	logic [CFG_BYTES-1:0][7:0] cfgBytes;

	// Read sequencing
	always_ff @(posedge clk) begin
		if (reset) begin
			readReq  <= 1'b0;
			pending  <= 1'b0;
			byteIdx  <= '0;
			loadDone <= 1'b0;
		end else begin
			loadDone <= 1'b0;
			if (start) begin
				readReq <= 1'b1;
				pending <= 1'b0;
				byteIdx <= '0;
			end else begin
				if (readReq && inResp.readAck) begin
					readReq <= 1'b0; // Wait for data before next request
					pending <= 1'b1;
				end
				if (pending && inResp.readDataValid) begin
					pending <= 1'b0;
					if (byteIdx == LAST_IDX) begin
						loadDone <= 1'b1; // All 16 bytes captured
					end else begin
						byteIdx <= byteIdx + 1'b1;
						readReq <= 1'b1;
					end
				end
			end
		end
	end

	// Byte capture
	always_ff @(posedge clk) begin
		if (pending && inResp.readDataValid)
			cfgBytes[byteIdx] <= inResp.readData;
	end

	always_comb begin
		inMem.readReq = readReq;
		inMem.readAdd = IN_ADDR_W'(byteIdx); // Zero-extended index
	end

	assign pdlConfig = cfgBytes;

endmodule

`default_nettype wire

//--- rtl/paramFetch.sv
/* Parameter fetch: reads the mode word and the challenge word from the host
   register file, then decodes the mode */
`default_nettype none

module paramFetch (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         start,       // Pulse from sequencer
	output sircPufPkg::regPort_t         regPort,
	input  sircPufPkg::regResp_t         regResp,
	output sircPufPkg::opMode_e          mode,        // Stable until next fetch
	output logic [sircPufPkg::REG_W-1:0] pcChallenge,
	output logic                         paramsValid  // One-cycle pulse
);
	import sircPufPkg::*;

	localparam logic [REG_ADDR_W-1:0] CHAL_ADDR = 1; // Second and last address
	localparam logic [REG_W-1:0]      MODE_CAL  = 0;
	localparam logic [REG_W-1:0]      MODE_TEMP = 1;

	logic                  busy;      // Words still expected
	logic                  wordCount; // Set after first word
	logic [1:0][REG_W-1:0] wordShift; // [1] mode word, [0] challenge word

	// Request side and word counting
	always_ff @(posedge clk) begin
		if (reset) begin
			busy            <= 1'b0;
			wordCount       <= 1'b0;
			regPort.cmdReq  <= 1'b0;
			regPort.address <= '0;
			paramsValid     <= 1'b0;
		end else begin
			paramsValid <= 1'b0;
			if (start) begin
				busy            <= 1'b1;
				wordCount       <= 1'b0;
				regPort.cmdReq  <= 1'b1; // First read at address 0
				regPort.address <= '0;
			end else if (busy) begin
				// Accepted read
				if (regPort.cmdReq && regResp.cmdAck) begin
					if (regPort.address == CHAL_ADDR)
						regPort.cmdReq <= 1'b0; // Both reads issued
					else
						regPort.address <= regPort.address + 1'b1;
				end
				if (regResp.readDataValid) begin
					wordCount <= 1'b1;
					if (wordCount) begin
						busy        <= 1'b0;
						paramsValid <= 1'b1; // Second word in
					end
				end
			end
		end
	end

	// Returned words shift in, oldest ends up in [1]
	always_ff @(posedge clk) begin
		if (busy && regResp.readDataValid)
			wordShift <= {wordShift[0], regResp.readData};
	end

	// Mode decode
	always_comb begin
		case (wordShift[1])
			MODE_CAL:  mode = calibrate;
			MODE_TEMP: mode = readTemp;
			default:   mode = normalTest; // Any other word
		endcase
	end

	assign pcChallenge = wordShift[0];

endmodule

`default_nettype wire

//--- rtl/responseWriter.sv
/* Output write-back: sends the raw response bytes in calibration, else
   copies resultLen buffered result bytes to the output memory */
`default_nettype none

module responseWriter #(
	parameter int resultLen = 64
) (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              start,       // Pulse from sequencer
	input  sircPufPkg::opMode_e               mode,
	input  logic [sircPufPkg::RESP_W-1:0]     rawResponse,
	output logic [sircPufPkg::RES_ADDR_W-1:0] rdAddr,
	input  logic [7:0]                        rdData,
	output sircPufPkg::outMemReq_t            outMem,
	input  logic                              outAck,
	output logic                              writeDone    // One-cycle pulse
);
	import sircPufPkg::*;

	localparam int LAST_RESULT = resultLen - 1;

	typedef enum logic [1:0] {stIdle, stFetch, stLoad, stWrite} wrState_e;

	wrState_e              state;
	logic [OUT_ADDR_W-1:0] byteIdx;   // Output address and buffer address
	logic                  writeReq;
	logic [7:0]            writeData;
	logic [7:0]            lowHold;   // Low response byte for second write
	logic                  lastByte;

	assign lastByte = (mode == calibrate) ? (byteIdx == OUT_ADDR_W'(1))
		: (byteIdx == LAST_RESULT[OUT_ADDR_W-1:0]);

	// Write sequencing
	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= stIdle;
			byteIdx   <= '0;
			writeReq  <= 1'b0;
			writeDone <= 1'b0;
		end else begin
			writeDone <= 1'b0;
			case (state)
				stIdle: if (start) begin
					byteIdx <= '0;
					if (mode == calibrate) begin
						writeReq <= 1'b1; // High byte goes out first
						state    <= stWrite;
					end else begin
						state <= stFetch;
					end
				end
				stFetch: state <= stLoad; // Buffer samples rdAddr
				stLoad: begin
					writeReq <= 1'b1;
					state    <= stWrite;
				end
				stWrite: if (outAck) begin
					if (lastByte) begin
						writeReq  <= 1'b0;
						writeDone <= 1'b1;
						state     <= stIdle;
					end else begin
						byteIdx <= byteIdx + 1'b1;
						if (mode != calibrate) begin
							writeReq <= 1'b0; // Next byte needs a buffer read
							state    <= stFetch;
						end
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

	// Write data, stable while the request stalls
	always_ff @(posedge clk) begin
		if (state == stIdle && start) begin
			lowHold   <= rawResponse[7:0];
			writeData <= rawResponse[RESP_W-1:8];
		end else if (state == stLoad) begin
			writeData <= rdData;
		end else if (state == stWrite && outAck && mode == calibrate) begin
			writeData <= lowHold;
		end
	end

	assign rdAddr = byteIdx;

	always_comb begin
		outMem.writeReq  = writeReq;
		outMem.writeAdd  = byteIdx;
		outMem.writeData = writeData;
	end

endmodule

`default_nettype wire

//--- rtl/resultBuffer.sv
/* Result buffer: byte RAM filled by the PUF engine and read back by the
   output write-back with one cycle of read latency */
`default_nettype none

module resultBuffer (
	input  logic                              clk,
	input  sircPufPkg::resultWrite_t          wr,     // Engine write port
	input  logic [sircPufPkg::RES_ADDR_W-1:0] rdAddr,
	output logic [7:0]                        rdData  // Valid one cycle after rdAddr
);
	import sircPufPkg::*;

	localparam int DEPTH = 2 ** RES_ADDR_W;

	logic [7:0] mem [DEPTH];

	// Engine side
	always_ff @(posedge clk) begin
		if (wr.we)
			mem[wr.addr] <= wr.data;
	end

	// Registered read for the write-back
	always_ff @(posedge clk) begin
		rdData <= mem[rdAddr];
	end

endmodule

`default_nettype wire

//--- rtl/sessionControl.sv
/* Session sequencer: follows the host run flag through fetch, load, compute
   and write-back, drives the engine trigger and clears the run flag */
`default_nettype none

module sessionControl #(
	parameter int calibWait = 10
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                userRunValue,
	output logic                userRunClear, // One-cycle pulse at session end
	input  sircPufPkg::opMode_e mode,
	input  logic                paramsValid,
	input  logic                loadDone,
	input  logic                testDone,
	input  logic                writeDone,
	output logic                fetchStart,
	output logic                loadStart,
	output logic                writeStart,
	output logic                calTrigger,
	output logic                testStart
);
	import sircPufPkg::*;

	localparam int WAIT_W    = $clog2(calibWait + 1);
	localparam int WAIT_LAST = calibWait - 1;

	typedef enum logic [2:0] {
		stIdle, stFetch, stLoad, stCompute, stWriteback, stClear
	} phase_e;

	phase_e            phase;
	logic [WAIT_W-1:0] waitCnt; // Cycles since calTrigger

	always_ff @(posedge clk) begin
		if (reset) begin
			phase        <= stIdle;
			waitCnt      <= '0;
			userRunClear <= 1'b0;
			fetchStart   <= 1'b0;
			loadStart    <= 1'b0;
			writeStart   <= 1'b0;
			calTrigger   <= 1'b0;
			testStart    <= 1'b0;
		end else begin
			fetchStart <= 1'b0; // Start strobes are single cycle
			loadStart  <= 1'b0;
			writeStart <= 1'b0;
			calTrigger <= 1'b0;
			case (phase)
				stIdle: if (userRunValue && !userRunClear) begin
					fetchStart <= 1'b1;
					phase      <= stFetch;
				end
				stFetch: if (paramsValid) begin
					loadStart <= 1'b1;
					phase     <= stLoad;
				end
				stLoad: if (loadDone) begin
					phase   <= stCompute;
					waitCnt <= '0;
					if (mode == calibrate)
						calTrigger <= 1'b1;
					else
						testStart <= 1'b1; // Held until testDone
				end
				stCompute: begin
					if (mode == calibrate) begin
						waitCnt <= waitCnt + 1'b1;
						// Write-back lands exactly calibWait cycles after trigger
						if (waitCnt == WAIT_LAST[WAIT_W-1:0]) begin
							writeStart <= 1'b1;
							phase      <= stWriteback;
						end
					end else if (testDone) begin
						testStart  <= 1'b0;
						writeStart <= 1'b1;
						phase      <= stWriteback;
					end
				end
				stWriteback: if (writeDone) begin
					userRunClear <= 1'b1;
					phase        <= stClear;
				end
				stClear: begin
					userRunClear <= 1'b0;
					phase        <= stIdle;
				end
				default: phase <= stIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/sircPufHandler.sv
/* Host-link session handler for the delay-line PUF board: wires the session
   blocks between the host ports and the external PUF engine */
`default_nettype none

module sircPufHandler #(
	parameter int resultLen = 64, // Result bytes per test session
	parameter int calibWait = 10  // Calibration wait in cycles
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     userRunValue,
	output logic                     userRunClear,
	output sircPufPkg::regPort_t     regPort,
	input  sircPufPkg::regResp_t     regResp,
	output sircPufPkg::inMemReq_t    inMem,
	input  sircPufPkg::inMemResp_t   inResp,
	output sircPufPkg::outMemReq_t   outMem,
	input  logic                     outAck,
	output sircPufPkg::pufCmd_t      pufCmd,
	input  sircPufPkg::pufStatus_t   pufStatus,
	input  sircPufPkg::resultWrite_t resultWr
);
	import sircPufPkg::*;

	////////////////////////////// Internal wiring
	logic                  fetchStart, loadStart, writeStart;
	logic                  paramsValid, loadDone, writeDone;
	logic                  calTrigger, testStart;
	opMode_e               mode;
	logic [REG_W-1:0]      pcChallenge;
	logic [CFG_W-1:0]      pdlConfig;
	logic [RES_ADDR_W-1:0] rdAddr;
	logic [7:0]            rdData;

	// Engine command bundle
	assign pufCmd = '{pdlConfig: pdlConfig, pcChallenge: pcChallenge, mode: mode,
		calTrigger: calTrigger, testStart: testStart};

	sessionControl #(.calibWait(calibWait)) uSession (
		.clk(clk), .reset(reset),
		.userRunValue(userRunValue), .userRunClear(userRunClear),
		.mode(mode), .paramsValid(paramsValid), .loadDone(loadDone),
		.testDone(pufStatus.testDone), .writeDone(writeDone),
		.fetchStart(fetchStart), .loadStart(loadStart), .writeStart(writeStart),
		.calTrigger(calTrigger), .testStart(testStart)
	);

	paramFetch uFetch (
		.clk(clk), .reset(reset), .start(fetchStart),
		.regPort(regPort), .regResp(regResp),
		.mode(mode), .pcChallenge(pcChallenge), .paramsValid(paramsValid)
	);

	challengeLoader uLoader (
		.clk(clk), .reset(reset), .start(loadStart),
		.inMem(inMem), .inResp(inResp),
		.pdlConfig(pdlConfig), .loadDone(loadDone)
	);

	// Engine fills it during compute
	resultBuffer uBuffer (
		.clk(clk), .wr(resultWr), .rdAddr(rdAddr), .rdData(rdData)
	);

	responseWriter #(.resultLen(resultLen)) uWriter (
		.clk(clk), .reset(reset), .start(writeStart),
		.mode(mode), .rawResponse(pufStatus.rawResponse),
		.rdAddr(rdAddr), .rdData(rdData),
		.outMem(outMem), .outAck(outAck), .writeDone(writeDone)
	);

endmodule

`default_nettype wire

//--- rtl/sircPufPkg.sv
/* Shared widths, operation mode and port structs of the PUF session handler
   for the host link and the PUF engine boundary */
`default_nettype none

package sircPufPkg;

	////////////////////////////// Widths
	localparam int REG_W      = 32;  // Parameter register word
	localparam int REG_ADDR_W = 8;   // Parameter register address
	localparam int IN_ADDR_W  = 17;  // Input memory address
	localparam int OUT_ADDR_W = 13;  // Output memory address
	localparam int CFG_BYTES  = 16;  // Delay-line config bytes
	localparam int CFG_W      = 128; // Packed delay-line config
	localparam int RESP_W     = 16;  // Raw engine response
	localparam int RES_ADDR_W = 13;  // Result buffer address

	// Decoded session mode
	typedef enum logic [1:0] {
		calibrate,
		readTemp,
		normalTest
	} opMode_e;

	////////////////////////////// Host side
	typedef struct packed {
		logic                  cmdReq;  // Held until acked
		logic [REG_ADDR_W-1:0] address;
	} regPort_t;

	typedef struct packed {
		logic             cmdAck;
		logic             readDataValid; // One per accepted read, in order
		logic [REG_W-1:0] readData;
	} regResp_t;

	typedef struct packed {
		logic                 readReq;
		logic [IN_ADDR_W-1:0] readAdd;
	} inMemReq_t;

	typedef struct packed {
		logic       readAck;
		logic       readDataValid;
		logic [7:0] readData;
	} inMemResp_t;

	typedef struct packed {
		logic                  writeReq;  // Stalls on ack low
		logic [OUT_ADDR_W-1:0] writeAdd;
		logic [7:0]            writeData;
	} outMemReq_t;

	////////////////////////////// Engine side
	typedef struct packed {
		logic [CFG_W-1:0] pdlConfig;
		logic [REG_W-1:0] pcChallenge;
		opMode_e          mode;
		logic             calTrigger; // One-cycle pulse
		logic             testStart;  // Level until testDone
	} pufCmd_t;

	typedef struct packed {
		logic              testDone;
		logic [RESP_W-1:0] rawResponse;
	} pufStatus_t;

	typedef struct packed {
		logic                  we;
		logic [RES_ADDR_W-1:0] addr;
		logic [7:0]            data;
	} resultWrite_t;

endpackage

`default_nettype wire

//--- sim/sessionControl_props.sv
/* Bound checks on the session sequencer: trigger and clear pulse widths,
   and no test start in calibration mode */
`default_nettype none

module sessionControlProps (
	input logic                clk,
	input logic                reset,
	input sircPufPkg::opMode_e mode,
	input logic                calTrigger,
	input logic                testStart,
	input logic                userRunClear
);
	import sircPufPkg::*;

	// Calibration trigger is a single-cycle pulse
	calTriggerPulse: assert property (@(posedge clk) disable iff (reset)
		calTrigger |=> !calTrigger)
		else $error("calTrigger held for more than one cycle");

	// Calibration sessions never start a test
	noTestInCalib: assert property (@(posedge clk) disable iff (reset)
		$rose(testStart) |-> (mode != calibrate))
		else $error("testStart rose in calibration mode");

	clearPulse: assert property (@(posedge clk) disable iff (reset)
		userRunClear |=> !userRunClear)
		else $error("userRunClear held for more than one cycle"); // One cycle only

endmodule

bind sessionControl sessionControlProps uSessionProps (
	.clk(clk), .reset(reset), .mode(mode), .calTrigger(calTrigger),
	.testStart(testStart), .userRunClear(userRunClear)
);

`default_nettype wire

//--- sim/sircPufTb.sv
/* Testbench for the PUF session handler: host register file, input and
   output memory and PUF engine models, sessions read from a data file */
`default_nettype none

module sircPufTb;
	import sircPufPkg::*;

	localparam int RESULT_LEN = 64;
	localparam int CALIB_WAIT = 10;
	localparam int MAX_SESS   = 16;
	localparam int WAIT_LIMIT = 2000; // Cycles before a session wait gives up

	logic         clk;
	logic         reset;
	logic         userRunValue;
	logic         userRunClear;
	regPort_t     regPort;
	regResp_t     regResp;
	inMemReq_t    inMem;
	inMemResp_t   inResp;
	outMemReq_t   outMem;
	logic         outAck;
	pufCmd_t      pufCmd;
	pufStatus_t   pufStatus;
	resultWrite_t resultWr;

	////////////////////////////// Session table
	logic [REG_W-1:0]  modeTab [MAX_SESS];
	logic [REG_W-1:0]  chalTab [MAX_SESS];
	logic [CFG_W-1:0]  cfgTab  [MAX_SESS]; // Byte i at bit 8*i
	logic [RESP_W-1:0] respTab [MAX_SESS];
	logic [7:0]        seedTab [MAX_SESS];
	int                sessCount;
	int                cur;                // Session the models serve

	logic [OUT_ADDR_W-1:0] wrAddrQ [$]; // Accepted output writes, in order
	logic [7:0]            wrDataQ [$];
	int                    cycleCnt = 0;
	int                    trigCycle;        // Edge that showed calTrigger
	int                    firstAcceptCycle; // Edge of first accepted write
	bit                    engineSaw;

	sircPufHandler #(.resultLen(RESULT_LEN), .calibWait(CALIB_WAIT)) DUT (
		.clk(clk), .reset(reset),
		.userRunValue(userRunValue), .userRunClear(userRunClear),
		.regPort(regPort), .regResp(regResp), .inMem(inMem), .inResp(inResp),
		.outMem(outMem), .outAck(outAck),
		.pufCmd(pufCmd), .pufStatus(pufStatus), .resultWr(resultWr)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) cycleCnt = cycleCnt + 1; // Read on falling edges only

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1);
	endtask

	// Mode word 0 calibrates, 1 reads temperature, anything else tests
	function automatic opMode_e expectedMode(input logic [REG_W-1:0] word);
		if (word == 0)
			return calibrate;
		if (word == 1)
			return readTemp;
		return normalTest;
	endfunction

	task automatic loadTestdata();
		int         fd;
		int         got;
		int         i;
		string      line;
		logic [REG_W-1:0]  m;
		logic [REG_W-1:0]  c;
		logic [RESP_W-1:0] r;
		logic [7:0]        s;
		logic [7:0]        b [CFG_BYTES];
		fd = $fopen("sim/sircPufTestdata.txt", "r");
		assert (fd != 0) else abortRun("Could not open the session data file");
		sessCount = 0;
		while (!$feof(fd) && sessCount < MAX_SESS) begin
			got = $fgets(line, fd);
			if (got > 0 && line.len() > 2 && line.substr(0, 1) != "//") begin // Skip comments
				got = $sscanf(line,
					"%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					m, c, b[0], b[1], b[2], b[3], b[4], b[5], b[6], b[7], b[8], b[9],
					b[10], b[11], b[12], b[13], b[14], b[15], r, s);
				assert (got == 20) else abortRun("A session data line has missing fields");
				modeTab[sessCount] = m;
				chalTab[sessCount] = c;
				respTab[sessCount] = r;
				seedTab[sessCount] = s;
				for (i = 0; i < CFG_BYTES; i++)
					cfgTab[sessCount][8*i +: 8] = b[i];
				sessCount++;
			end
		end
		$fclose(fd);
		assert (sessCount > 0) else abortRun("The session data file holds no sessions");
	endtask

	task automatic checkIdleOutputs(input string phase);
		assert (!regPort.cmdReq && !inMem.readReq && !outMem.writeReq && !pufCmd.calTrigger
			&& !pufCmd.testStart && !userRunClear)
			else abortRun($sformatf("error at time %0t: control output active %s", $time, phase));
	endtask

	// Engine command at the first trigger of a session
	task automatic checkCommand();
		int i;
		assert (pufCmd.mode == expectedMode(modeTab[cur])) else abortRun($sformatf(
			"error at time %0t: session %0d mode %0d, expected %0d", $time, cur,
			pufCmd.mode, expectedMode(modeTab[cur])));
		assert (pufCmd.calTrigger == (expectedMode(modeTab[cur]) == calibrate))
			else abortRun($sformatf("error at time %0t: wrong trigger kind", $time));
		assert (pufCmd.pcChallenge == chalTab[cur]) else abortRun($sformatf(
			"error at time %0t: challenge %h, expected %h", $time,
			pufCmd.pcChallenge, chalTab[cur]));
		for (i = 0; i < CFG_BYTES; i++) begin
			assert (pufCmd.pdlConfig[8*i +: 8] == cfgTab[cur][8*i +: 8]) else abortRun($sformatf(
				"error at time %0t: config byte %0d is %h, expected %h", $time, i,
				pufCmd.pdlConfig[8*i +: 8], cfgTab[cur][8*i +: 8]));
		end
	endtask

	////////////////////////////// Host models
	// Register file, serial: ack after 0..3 cycles, data 1..3 cycles later
	initial begin : regFileModel
		int                    dly;
		logic [REG_ADDR_W-1:0] addr;
		regResp = '0;
		forever begin
			@(negedge clk);
			regResp.cmdAck        = 1'b0;
			regResp.readDataValid = 1'b0;
			if (!reset && regPort.cmdReq) begin
				dly = $urandom_range(3, 0);
				repeat (dly) @(negedge clk);
				addr = regPort.address;
				assert (addr <= 1) else abortRun($sformatf(
					"error at time %0t: register read at address %0d", $time, addr));
				regResp.cmdAck = 1'b1;
				@(negedge clk);
				regResp.cmdAck = 1'b0;
				dly = $urandom_range(3, 1);
				repeat (dly - 1) @(negedge clk);
				regResp.readData      = (addr == 0) ? modeTab[cur] : chalTab[cur];
				regResp.readDataValid = 1'b1;
			end
		end
	end

	// Input memory holds the config bytes at addresses 0..15
	initial begin : inMemModel
		int dly;
		int addr;
		inResp = '0;
		forever begin
			@(negedge clk);
			inResp.readAck       = 1'b0;
			inResp.readDataValid = 1'b0;
			if (!reset && inMem.readReq) begin
				dly = $urandom_range(3, 0);
				repeat (dly) @(negedge clk);
				addr = int'(inMem.readAdd);
				assert (addr < CFG_BYTES) else abortRun($sformatf(
					"error at time %0t: input read at address %0d", $time, addr));
				inResp.readAck = 1'b1;
				@(negedge clk);
				inResp.readAck = 1'b0;
				dly = $urandom_range(3, 1);
				repeat (dly - 1) @(negedge clk);
				inResp.readData      = cfgTab[cur][8*addr +: 8];
				inResp.readDataValid = 1'b1;
			end
		end
	end

	// Output memory records each accepted write
	initial begin : outMemModel
		int                    dly;
		logic [OUT_ADDR_W-1:0] holdAddr;
		logic [7:0]            holdData;
		outAck = 1'b0;
		forever begin
			@(negedge clk);
			outAck = 1'b0;
			if (!reset && outMem.writeReq) begin
				holdAddr = outMem.writeAdd;
				holdData = outMem.writeData;
				dly = $urandom_range(3, 0);
				repeat (dly) begin
					@(negedge clk);
					assert (outMem.writeReq && outMem.writeAdd == holdAddr
						&& outMem.writeData == holdData) else abortRun($sformatf(
						"error at time %0t: write request changed while stalled", $time));
				end
				if (wrAddrQ.size() == 0)
					firstAcceptCycle = cycleCnt + 1; // Accepted on the next rising edge
				wrAddrQ.push_back(holdAddr);
				wrDataQ.push_back(holdData);
				outAck = 1'b1;
			end
		end
	end

	////////////////////////////// Engine model
	initial begin : engineModel
		int k;
		pufStatus = '0;
		resultWr  = '0;
		forever begin
			@(negedge clk);
			resultWr.we        = 1'b0;
			pufStatus.testDone = 1'b0;
			if (!reset && (pufCmd.calTrigger || pufCmd.testStart)) begin
				checkCommand();
				engineSaw = 1'b1;
				if (pufCmd.calTrigger) begin
					trigCycle             = cycleCnt;
					pufStatus.rawResponse = respTab[cur];
				end else begin
					for (k = 0; k < RESULT_LEN; k++) begin
						assert (pufCmd.testStart) else abortRun($sformatf(
							"error at time %0t: testStart dropped before testDone", $time));
						resultWr.we   = 1'b1;
						resultWr.addr = RES_ADDR_W'(k);
						resultWr.data = seedTab[cur] + 8'(k); // Wraps modulo 256
						@(negedge clk);
					end
					resultWr.we        = 1'b0;
					pufStatus.testDone = 1'b1;
					@(negedge clk);
					pufStatus.testDone = 1'b0;
					assert (!pufCmd.testStart) else abortRun($sformatf(
						"error at time %0t: testStart still high after testDone", $time));
				end
			end
		end
	end

	////////////////////////////// Session checks
	task automatic checkWrites(input int s);
		int         k;
		int         expCount;
		logic [7:0] expData;
		bit         isCal;
		isCal    = (expectedMode(modeTab[s]) == calibrate);
		expCount = isCal ? 2 : RESULT_LEN;
		assert (engineSaw) else abortRun($sformatf("Session %0d never triggered the engine", s));
		assert (wrAddrQ.size() == expCount) else abortRun($sformatf(
			"error at time %0t: session %0d made %0d writes, expected %0d", $time, s,
			wrAddrQ.size(), expCount));
		for (k = 0; k < expCount; k++) begin
			if (isCal)
				expData = (k == 0) ? respTab[s][15:8] : respTab[s][7:0]; // High byte first
			else
				expData = seedTab[s] + 8'(k);
			assert (wrAddrQ[k] == OUT_ADDR_W'(k) && wrDataQ[k] == expData) else abortRun($sformatf(
				"error at time %0t: write %0d went to %0d with %h, expected %0d with %h",
				$time, k, wrAddrQ[k], wrDataQ[k], k, expData));
		end
		if (isCal) begin
			assert (firstAcceptCycle - trigCycle >= CALIB_WAIT) else abortRun($sformatf(
				"error at time %0t: calibration write %0d cycles after trigger", $time,
				firstAcceptCycle - trigCycle));
		end
	endtask

	// One host session, entered and left right after a falling edge
	task automatic runSession(input int s);
		int guard;
		cur = s;
		wrAddrQ.delete();
		wrDataQ.delete();
		engineSaw    = 1'b0;
		userRunValue = 1'b1; // Host raises the run flag
		guard = 0;
		do begin
			@(negedge clk);
			guard++;
			assert (guard < WAIT_LIMIT) else abortRun($sformatf(
				"Timed out waiting for the end of session %0d", s));
		end while (!userRunClear);
		userRunValue = 1'b0;
		@(negedge clk);
		assert (!userRunClear) else abortRun($sformatf(
			"error at time %0t: userRunClear longer than one cycle", $time));
		checkWrites(s); // Also catches writes after the clear
		@(negedge clk);
	endtask

	initial begin : mainFlow
		int s;
		reset        = 1'b1;
		userRunValue = 1'b0;
		cur          = 0;
		void'($urandom(32'hca35));
		loadTestdata();
		repeat (16) begin
			@(negedge clk);
			checkIdleOutputs("during reset");
		end
		reset = 1'b0;
		@(negedge clk);
		checkIdleOutputs("after reset");
		for (s = 0; s < sessCount; s++)
			runSession(s);
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/sircPufTestdata.txt
// mode challenge cfg0 cfg1 ... cfg15 rawResponse seed, all hex
// one session per line, cfg byte i sits at input memory address i
00000000 a5c3e117 01 23 45 67 89 ab cd ef fe dc ba 98 76 54 32 10 3c9e 00
00000002 0badf00d 11 22 33 44 55 66 77 88 99 aa bb cc dd ee ff 00 1234 10
00000001 5a5a0ff0 f0 e1 d2 c3 b4 a5 96 87 78 69 5a 4b 3c 2d 1e 0f beef f0
00000007 deadbeef 00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 0000 7e
00000000 13579bdf 80 40 20 10 08 04 02 01 ff 7f 3f 1f 0f 07 03 01 ff01 22
ffffffff 2468ace0 c3 3c a5 5a 96 69 0f f0 e7 7e db bd 81 18 42 24 5555 81
00000001 00000000 aa 55 aa 55 aa 55 aa 55 aa 55 aa 55 aa 55 aa 55 0f0f 00
00000100 cafef00d 9e 37 79 b9 7f 4a 7c 15 f3 9c c3 5e 2d 6b 08 e1 a0a0 c4
00000000 fedcba98 de ad be ef 01 02 03 04 05 06 07 08 c0 ff ee 11 80fe 5d
80000001 76543210 31 41 59 26 53 58 97 93 23 84 62 64 33 83 27 95 7e01 3f

//--- sircPuf.f
rtl/sircPufPkg.sv
rtl/paramFetch.sv
rtl/challengeLoader.sv
rtl/resultBuffer.sv
rtl/responseWriter.sv
rtl/sessionControl.sv
rtl/sircPufHandler.sv
sim/sessionControl_props.sv
sim/sircPufTb.sv
